// ==== filelist.f ====
+incdir+rtl
rtl/noc_pkg.sv
rtl/noc_link_if.sv
rtl/noc_input_port.sv
rtl/spidergon_node.sv
rtl/spidergon_top.sv
sim/tb_spidergon.sv

// ==== rtl/noc_defs.svh ====
// network sizing constants, included by the package, the RTL and the testbench
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// node count, must be a multiple of 4 so the quarter split in routing is exact
`define NOC_NUM_NODES 8

// width of the packet payload in bits
`define NOC_PAYLOAD_WIDTH 16

// flits held by one input buffer
`define NOC_BUFFER_DEPTH 4

// occupancy at or above which an input tells its sender to stop
// depth minus this level must cover the flits already in flight on the link
`define NOC_STOP_LEVEL 2

`endif

// ==== rtl/noc_input_port.sv ====
// input buffer of one node port, presents the head flit with its route and drives stop back
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_input_port (
	input  logic               clk,
	input  logic               reset,
	input  noc_pkg::node_id_t  node_id,
	noc_link_if.receiver       in,
	output logic               head_valid,
	output noc_pkg::node_id_t  head_dest,
	output noc_pkg::node_id_t  head_src,
	output noc_pkg::payload_t  head_payload,
	output noc_pkg::port_e     head_dir,
	input  logic               pop
);
	import noc_pkg::*;

	localparam int DEPTH = `NOC_BUFFER_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// flit storage, split by field
	node_id_t dest_mem    [DEPTH];
	node_id_t src_mem     [DEPTH];
	payload_t payload_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// pointer step with wrap at the buffer depth
	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// every valid cycle is a write, there is no acknowledge on the link
	always_ff @(posedge clk)
	begin
		if (in.valid)
		begin
			dest_mem[wr_ptr]    <= in.dest;
			src_mem[wr_ptr]     <= in.src;
			payload_mem[wr_ptr] <= in.payload;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (in.valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({in.valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head flit, held until the switch grants it
	assign head_valid   = (count != '0);
	assign head_dest    = dest_mem[rd_ptr];
	assign head_src     = src_mem[rd_ptr];
	assign head_payload = payload_mem[rd_ptr];
	assign head_dir     = route_dir(node_id, dest_mem[rd_ptr]);

	// on/off level to the sender, taken from the registered occupancy
	assign in.stop = (count >= CNT_W'(`NOC_STOP_LEVEL));

	// the sender honours stop, so the slack above the stop level is never used up
	assert property (@(posedge clk) disable iff (reset)
		in.valid |-> (count < CNT_W'(DEPTH)))
	else
		$error("input port of node %0d written while full", node_id);

	// the switch only grants a flit that is at the head
	assert property (@(posedge clk) disable iff (reset)
		pop |-> (count != '0))
	else
		$error("input port of node %0d popped while empty", node_id);

endmodule

// ==== rtl/noc_link_if.sv ====
// one directed link between neighbouring nodes, sender to receiver with an on/off stop level
`timescale 1ns/100ps

interface noc_link_if;
	import noc_pkg::*;

	// flit fields, a flit moves in every cycle where valid is high
	logic     valid;
	node_id_t dest;
	node_id_t src;
	payload_t payload;

	// receiver buffer at or above its stop level
	logic     stop;

	modport sender (
		output valid,
		output dest,
		output src,
		output payload,
		input  stop
	);

	modport receiver (
		input  valid,
		input  dest,
		input  src,
		input  payload,
		output stop
	);

endinterface

// ==== rtl/noc_pkg.sv ====
// shared types and the routing rule of the network, imported by every RTL block
`include "noc_defs.svh"

package noc_pkg;

	typedef logic [$clog2(`NOC_NUM_NODES)-1:0] node_id_t;

	typedef logic [`NOC_PAYLOAD_WIDTH-1:0] payload_t;

	// output direction of a node, LOCAL is the eject port
	typedef enum logic [1:0] {
		ANTI_CLOCKWISE = 2'd0,
		CLOCKWISE      = 2'd1,
		ACROSS         = 2'd2,
		LOCAL          = 2'd3
	} port_e;

	// across-first shortest path, from the ring distance to the destination
	function automatic port_e route_dir(node_id_t cur, node_id_t dest);
		int r;
		r = (int'(dest) - int'(cur) + `NOC_NUM_NODES) % `NOC_NUM_NODES;
		if (r == 0)
			return LOCAL;
		if (r <= `NOC_NUM_NODES / 4)
			return CLOCKWISE;
		if (r >= 3 * `NOC_NUM_NODES / 4)
			return ANTI_CLOCKWISE;
		return ACROSS;
	endfunction

endpackage

// ==== rtl/spidergon_node.sv ====
// one router node with four buffered inputs, a round-robin switch and registered outputs
`timescale 1ns/100ps

module spidergon_node #(
	parameter noc_pkg::node_id_t NODE_ID = '0
) (
	input  logic               clk,
	input  logic               reset,
	noc_link_if.receiver       acw_in,
	noc_link_if.receiver       cw_in,
	noc_link_if.receiver       across_in,
	noc_link_if.sender         acw_out,
	noc_link_if.sender         cw_out,
	noc_link_if.sender         across_out,
	input  logic               inject_valid,
	input  noc_pkg::node_id_t  inject_dest,
	input  noc_pkg::payload_t  inject_payload,
	output logic               inject_stop,
	output logic               eject_valid,
	output noc_pkg::node_id_t  eject_src,
	output noc_pkg::payload_t  eject_payload
);
	import noc_pkg::*;

	// inputs and outputs share the index order of port_e, LOCAL is inject or eject
	localparam int NUM_PORTS = 4;
	localparam int NUM_LINKS = 3;

	// local injection enters through the same buffer as a link
	noc_link_if inj_link ();

	logic     [NUM_PORTS-1:0] head_valid;
	node_id_t                 head_dest    [NUM_PORTS];
	node_id_t                 head_src     [NUM_PORTS];
	payload_t                 head_payload [NUM_PORTS];
	port_e                    head_dir     [NUM_PORTS];
	logic     [NUM_PORTS-1:0] pop;

	// req[o][i] and grant[o][i] are indexed by output, then input
	logic [NUM_PORTS-1:0] req   [NUM_PORTS];
	logic [NUM_PORTS-1:0] grant [NUM_PORTS];
	logic [1:0]           win    [NUM_PORTS];
	logic [1:0]           rr_ptr [NUM_PORTS];
	logic [NUM_PORTS-1:0] out_free;

	logic     [NUM_PORTS-1:0] out_valid;
	node_id_t                 out_dest    [NUM_LINKS];
	node_id_t                 out_src     [NUM_PORTS];
	payload_t                 out_payload [NUM_PORTS];

	assign inj_link.valid   = inject_valid;
	assign inj_link.dest    = inject_dest;
	assign inj_link.src     = NODE_ID;
	assign inj_link.payload = inject_payload;
	assign inject_stop      = inj_link.stop;

	noc_input_port i_acw_port (
		.clk(clk), .reset(reset), .node_id(NODE_ID), .in(acw_in),
		.head_valid(head_valid[ANTI_CLOCKWISE]), .head_dest(head_dest[ANTI_CLOCKWISE]),
		.head_src(head_src[ANTI_CLOCKWISE]), .head_payload(head_payload[ANTI_CLOCKWISE]),
		.head_dir(head_dir[ANTI_CLOCKWISE]), .pop(pop[ANTI_CLOCKWISE])
	);

	noc_input_port i_cw_port (
		.clk(clk), .reset(reset), .node_id(NODE_ID), .in(cw_in),
		.head_valid(head_valid[CLOCKWISE]), .head_dest(head_dest[CLOCKWISE]),
		.head_src(head_src[CLOCKWISE]), .head_payload(head_payload[CLOCKWISE]),
		.head_dir(head_dir[CLOCKWISE]), .pop(pop[CLOCKWISE])
	);

	noc_input_port i_across_port (
		.clk(clk), .reset(reset), .node_id(NODE_ID), .in(across_in),
		.head_valid(head_valid[ACROSS]), .head_dest(head_dest[ACROSS]),
		.head_src(head_src[ACROSS]), .head_payload(head_payload[ACROSS]),
		.head_dir(head_dir[ACROSS]), .pop(pop[ACROSS])
	);

	noc_input_port i_inj_port (
		.clk(clk), .reset(reset), .node_id(NODE_ID), .in(inj_link),
		.head_valid(head_valid[LOCAL]), .head_dest(head_dest[LOCAL]),
		.head_src(head_src[LOCAL]), .head_payload(head_payload[LOCAL]),
		.head_dir(head_dir[LOCAL]), .pop(pop[LOCAL])
	);

	// a link output is free while its receiver shows no stop, eject never stalls
	assign out_free[ANTI_CLOCKWISE] = !acw_out.stop;
	assign out_free[CLOCKWISE]      = !cw_out.stop;
	assign out_free[ACROSS]         = !across_out.stop;
	assign out_free[LOCAL]          = 1'b1;

	for (genvar o = 0; o < NUM_PORTS; o++)
	begin : g_out
		always_comb
		begin
			for (int i = 0; i < NUM_PORTS; i++)
				req[o][i] = head_valid[i] && (head_dir[i] == port_e'(o));
		end

		// search from the pointer, first requester wins
		always_comb
		begin : arb
			logic       found;
			logic [1:0] idx;
			found    = 1'b0;
			win[o]   = rr_ptr[o];
			grant[o] = '0;
			for (int k = 0; k < NUM_PORTS; k++)
			begin
				idx = rr_ptr[o] + 2'(k);
				if (!found && req[o][idx])
				begin
					found  = 1'b1;
					win[o] = idx;
				end
			end
			if (found && out_free[o])
				grant[o][win[o]] = 1'b1;
		end

		// pointer moves past the winner
		always_ff @(posedge clk)
		begin
			if (reset)
				rr_ptr[o] <= 2'(ANTI_CLOCKWISE);
			else if (|grant[o])
				rr_ptr[o] <= win[o] + 2'd1;
		end

		always_ff @(posedge clk)
		begin
			if (reset)
				out_valid[o] <= 1'b0;
			else
				out_valid[o] <= |grant[o];
		end

		always_ff @(posedge clk)
		begin
			if (|grant[o])
			begin
				out_src[o]     <= head_src[win[o]];
				out_payload[o] <= head_payload[win[o]];
			end
		end

		if (o != LOCAL)
		begin : g_link
			// only links carry the destination onward
			always_ff @(posedge clk)
			begin
				if (|grant[o])
					out_dest[o] <= head_dest[win[o]];
			end
		end
	end

	// each input requests one output, so at most one arbiter may pick it
	for (genvar i = 0; i < NUM_PORTS; i++)
	begin : g_in
		always_comb
		begin
			pop[i] = 1'b0;
			for (int o = 0; o < NUM_PORTS; o++)
				pop[i] = pop[i] | grant[o][i];
		end

		assert property (@(posedge clk) disable iff (reset)
			$onehot0({grant[3][i], grant[2][i], grant[1][i], grant[0][i]}))
		else
			$error("node %0d input %0d granted twice", NODE_ID, i);
	end

	assign acw_out.valid      = out_valid[ANTI_CLOCKWISE];
	assign acw_out.dest       = out_dest[ANTI_CLOCKWISE];
	assign acw_out.src        = out_src[ANTI_CLOCKWISE];
	assign acw_out.payload    = out_payload[ANTI_CLOCKWISE];

	assign cw_out.valid       = out_valid[CLOCKWISE];
	assign cw_out.dest        = out_dest[CLOCKWISE];
	assign cw_out.src         = out_src[CLOCKWISE];
	assign cw_out.payload     = out_payload[CLOCKWISE];

	assign across_out.valid   = out_valid[ACROSS];
	assign across_out.dest    = out_dest[ACROSS];
	assign across_out.src     = out_src[ACROSS];
	assign across_out.payload = out_payload[ACROSS];

	assign eject_valid   = out_valid[LOCAL];
	assign eject_src     = out_src[LOCAL];
	assign eject_payload = out_payload[LOCAL];

	// a flit on a link was granted while that link's receiver showed no stop
	assert property (@(posedge clk) disable iff (reset)
		acw_out.valid |-> !$past(acw_out.stop))
	else
		$error("node %0d sent anticlockwise against stop", NODE_ID);

	assert property (@(posedge clk) disable iff (reset)
		cw_out.valid |-> !$past(cw_out.stop))
	else
		$error("node %0d sent clockwise against stop", NODE_ID);

	assert property (@(posedge clk) disable iff (reset)
		across_out.valid |-> !$past(across_out.stop))
	else
		$error("node %0d sent across against stop", NODE_ID);

endmodule

// ==== rtl/spidergon_top.sv ====
// spidergon network top, ring and across wiring of all nodes with per-node inject and eject ports
`timescale 1ns/100ps
`include "noc_defs.svh"

module spidergon_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`NOC_NUM_NODES-1:0]   inject_valid,
	input  noc_pkg::node_id_t           inject_dest    [`NOC_NUM_NODES],
	input  noc_pkg::payload_t           inject_payload [`NOC_NUM_NODES],
	output logic [`NOC_NUM_NODES-1:0]   inject_stop,
	output logic [`NOC_NUM_NODES-1:0]   eject_valid,
	output noc_pkg::node_id_t           eject_src      [`NOC_NUM_NODES],
	output noc_pkg::payload_t           eject_payload  [`NOC_NUM_NODES]
);
	import noc_pkg::*;

	localparam int NUM_NODES = `NOC_NUM_NODES;

	// links named by the sending side of node n
	noc_link_if cw_link     [NUM_NODES] ();
	noc_link_if acw_link    [NUM_NODES] ();
	noc_link_if across_link [NUM_NODES] ();

	for (genvar n = 0; n < NUM_NODES; n++)
	begin : g_node
		// n-1 sends clockwise into our anticlockwise side
		// n+1 sends anticlockwise into our clockwise side
		// the opposite node sends across
		spidergon_node #(
			.NODE_ID(node_id_t'(n))
		) i_node (
			.clk            (clk),
			.reset          (reset),
			.acw_in         (cw_link[(n + NUM_NODES - 1) % NUM_NODES]),
			.cw_in          (acw_link[(n + 1) % NUM_NODES]),
			.across_in      (across_link[(n + NUM_NODES / 2) % NUM_NODES]),
			.acw_out        (acw_link[n]),
			.cw_out         (cw_link[n]),
			.across_out     (across_link[n]),
			.inject_valid   (inject_valid[n]),
			.inject_dest    (inject_dest[n]),
			.inject_payload (inject_payload[n]),
			.inject_stop    (inject_stop[n]),
			.eject_valid    (eject_valid[n]),
			.eject_src      (eject_src[n]),
			.eject_payload  (eject_payload[n])
		);
	end

endmodule

// ==== sim/tb_spidergon.sv ====
// self-checking testbench for the spidergon network, random traffic against a scoreboard of queues
`timescale 1ns/100ps
`include "noc_defs.svh"

module tb_spidergon;

	localparam int NODES = `NOC_NUM_NODES;
	localparam int PW    = `NOC_PAYLOAD_WIDTH;
	localparam int IDW   = $clog2(NODES);

	logic                 clk;
	logic                 reset;
	logic [NODES-1:0]     inject_valid;
	logic [IDW-1:0]       inject_dest    [NODES];
	logic [PW-1:0]        inject_payload [NODES];
	logic [NODES-1:0]     inject_stop;
	logic [NODES-1:0]     eject_valid;
	logic [IDW-1:0]       eject_src      [NODES];
	logic [PW-1:0]        eject_payload  [NODES];

	// one queue per source and destination pair, index is src * NODES + dest
	logic [PW-1:0] sb_q [NODES*NODES][$];

	logic [31:0] rng_state;
	int          seq;
	int          injected;
	int          ejected;
	string       test_name;

	spidergon_top i_dut (
		.clk            (clk),
		.reset          (reset),
		.inject_valid   (inject_valid),
		.inject_dest    (inject_dest),
		.inject_payload (inject_payload),
		.inject_stop    (inject_stop),
		.eject_valid    (eject_valid),
		.eject_src      (eject_src),
		.eject_payload  (eject_payload)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// packets still waiting in the scoreboard for their ejection
	function automatic int pending_packets();
		int total;
		total = 0;
		for (int i = 0; i < NODES * NODES; i++)
			total += sb_q[i].size();
		return total;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "run stopped on error");
	endtask

	// presents one packet on a node for the coming rising edge and records it
	task automatic send_packet(input int node, input int dest, input logic [PW-1:0] payload);
		inject_valid[node]   = 1'b1;
		inject_dest[node]    = IDW'(dest);
		inject_payload[node] = payload;
		sb_q[node * NODES + dest].push_back(payload);
		injected++;
		seq++;
	endtask

	task automatic wait_stop_low(input int node, input int limit);
		int cycles;
		cycles = 0;
		while (inject_stop[node])
		begin
			@(negedge clk);
			cycles++;
			if (cycles > limit)
				report_error($sformatf("%s: inject_stop of node %0d stayed high too long",
					test_name, node));
		end
	endtask

	// waits until every scoreboard queue is empty
	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		while (pending_packets() != 0)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > limit)
				report_error($sformatf("%s: network did not drain, %0d of %0d packets ejected",
					test_name, ejected, injected));
		end
	endtask

	// outputs are registered on the rising edge, so they are read at the falling edge
	always @(negedge clk)
	begin : monitor
		int            idx;
		logic [PW-1:0] exp_payload;
		if (!reset)
		begin
			for (int n = 0; n < NODES; n++)
			begin
				if (eject_valid[n])
				begin
					if ($isunknown(eject_src[n]))
						report_error($sformatf("%s: node %0d ejected a packet with unknown src",
							test_name, n));
					idx = int'(eject_src[n]) * NODES + n;
					if (sb_q[idx].size() == 0)
						report_error($sformatf("%s: node %0d ejected an unexpected packet from %0d",
							test_name, n, eject_src[n]));
					exp_payload = sb_q[idx].pop_front();
					check({test_name, " pair_order payload"}, exp_payload, eject_payload[n]);
					ejected++;
				end
			end
		end
	end

	initial
	begin : main
		int  cycles;
		int  limit;
		bit  saw_stop;
		logic [31:0] r;
		rng_state    = 32'd30337;
		seq          = 0;
		injected     = 0;
		ejected      = 0;
		test_name    = "reset";
		reset        = 1'b1;
		inject_valid = '0;
		for (int n = 0; n < NODES; n++)
		begin
			inject_dest[n]    = '0;
			inject_payload[n] = '0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_name = "reset_quiet";
		repeat (20)
		begin
			@(negedge clk);
			check("reset_quiet inject_stop", 0, inject_stop);
			check("reset_quiet eject_valid", 0, eject_valid);
		end

		test_name = "self_delivery";
		for (int n = 0; n < NODES; n++)
		begin
			wait_stop_low(n, 50);
			rng_state = xorshift32(rng_state);
			send_packet(n, n, PW'(rng_state));
			@(negedge clk);
			inject_valid = '0;
			wait_drain(50);
		end

		// about one packet in four cycles per node keeps the ring moderately loaded
		test_name = "random_traffic";
		cycles    = 0;
		limit     = injected + 2000;
		while (injected < limit)
		begin
			@(negedge clk);
			inject_valid = '0;
			for (int n = 0; n < NODES; n++)
			begin
				rng_state = xorshift32(rng_state);
				r = rng_state;
				if (injected < limit && !inject_stop[n] && r[1:0] == 2'd0)
					send_packet(n, int'(r[10:8]), {r[18:16], 13'(seq)});
			end
			cycles++;
			if (cycles > 20000)
				report_error("random_traffic: injection of 2000 packets took too long");
		end
		@(negedge clk);
		inject_valid = '0;
		wait_drain(5000);

		test_name = "hotspot_backpressure";
		saw_stop  = 1'b0;
		repeat (500)
		begin
			@(negedge clk);
			inject_valid = '0;
			for (int n = 0; n < NODES; n++)
			begin
				if (inject_stop[n])
					saw_stop = 1'b1;
				else
				begin
					rng_state = xorshift32(rng_state);
					send_packet(n, 0, {rng_state[2:0], 13'(seq)});
				end
			end
		end
		@(negedge clk);
		inject_valid = '0;
		check("hotspot_backpressure inject_stop seen", 1, saw_stop);
		wait_drain(5000);

		$display("Test OK");
		$finish;
	end

endmodule
